// File: src.f
rtl/shell_pkg.sv
rtl/bridge_settings.sv
rtl/stick_deadzone.sv
rtl/datatable_poller.sv
rtl/video_frame_formatter.sv
rtl/pocket_core_shell.sv
verification/shell_props.sv
verification/tb_pocket_core_shell.sv

// File: Makefile
# Verilator build and run of the core control shell testbench

SIM = obj_dir/Vtb_pocket_core_shell

all: run

$(SIM): src.f rtl/*.sv verification/*.sv
	verilator --binary --timing --assert -j 0 --top-module tb_pocket_core_shell -f src.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: verification/tb_pocket_core_shell.sv
// testbench for the core control shell
// reference model of options, soft reset, stick, poller and video,
// compared against the DUT in the middle of every cycle

`default_nettype none

module tb_pocket_core_shell;

  timeunit 1ns;
  timeprecision 100ps;

  import shell_pkg::*;

  localparam int unsigned clk_period   = 40;
  localparam int unsigned reset_cycles = 8;
  localparam int unsigned cycle_limit  = 20000;
  localparam logic [31:0] rand_seed    = 32'h3faa0914;

  // DUT ports
  logic            clk_74a;
  logic            pll_core_locked;
  logic            bridge_wr, h_blank, v_blank, hsync_in, vsync_in, pal;
  bridge_word_t    bridge_addr, bridge_wr_data, cont1_joy, datatable_q;
  bridge_word_t    datatable_data, rom_file_size;
  logic            core_reset, multitap_enabled, lightgun_enabled, lightgun_type;
  logic            mouse_enabled, datatable_wren, video_de, video_hs, video_vs;
  stick_axis_t     dpad_aim_speed, p1_stick_x, p1_stick_y;
  sram_size_t      sram_size;
  datatable_addr_t datatable_addr;
  rgb_t            rgb_in, video_rgb;

  // reference model
  int unsigned     hold_left;
  int unsigned     cycle_count;
  logic            m_multitap, m_lg_en, m_lg_type, m_mouse, m_43;
  stick_axis_t     m_aim, m_dz, m_sx, m_sy;
  poll_phase_t     m_phase;
  logic            m_wren, m_rom_valid;
  datatable_addr_t m_addr;
  bridge_word_t    m_data, m_rom;
  logic            m_de, m_hs, m_vs, m_hs_prev, m_vs_prev;
  rgb_t            m_rgb;

  pocket_core_shell i_pocket_core_shell (.*);

  initial begin
    clk_74a = 1'b0;
    forever #(clk_period / 2) clk_74a = ~clk_74a;
  end

  ////////////////////
  // reference functions

  // raw axes pass only when the summed distance exceeds the deadzone
  function automatic logic stick_outside(stick_axis_t x, stick_axis_t y, stick_axis_t dz);
    int dx;
    int dy;
    dx = x[7] ? int'(x[6:0]) : 128 - int'(x[6:0]);
    dy = y[7] ? int'(y[6:0]) : 128 - int'(y[6:0]);
    return (dx + dy) > int'(dz);
  endfunction

  function automatic bridge_word_t save_bytes_for(sram_size_t code);
    if (code == 4'd0) begin
      return 32'd0;
    end else begin
      return 32'd1024 << code;
    end
  endfunction

  // pal at bit 14 and 4:3 at bit 13
  function automatic rgb_t status_word(logic pal_flag, logic flag_43);
    rgb_t w;
    w     = '0;
    w[14] = pal_flag;
    w[13] = flag_43;
    return w;
  endfunction

  task automatic check_value(input bridge_word_t got, input bridge_word_t exp,
                             input string what);
    assert (got === exp) else begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic reset_model();
    hold_left = 0;
    {m_multitap, m_lg_en, m_lg_type, m_mouse, m_43} = '0;
    m_aim       = '0;
    m_dz        = '0;
    m_sx        = 8'd128;
    m_sy        = 8'd128;
    m_phase     = '0;
    m_wren      = 1'b0;
    m_addr      = '0;
    m_data      = '0;
    m_rom_valid = 1'b0;
    {m_de, m_hs, m_vs, m_hs_prev, m_vs_prev} = '0;
    m_rgb       = '0;
  endtask

  task automatic compare_outputs();
    check_value(32'(core_reset), 32'(hold_left != 0), "core_reset");
    check_value(32'(multitap_enabled), 32'(m_multitap), "multitap_enabled");
    check_value(32'(lightgun_enabled), 32'(m_lg_en), "lightgun_enabled");
    check_value(32'(lightgun_type), 32'(m_lg_type), "lightgun_type");
    check_value(32'(mouse_enabled), 32'(m_mouse), "mouse_enabled");
    check_value(32'(dpad_aim_speed), 32'(m_aim), "dpad_aim_speed");
    check_value(32'(p1_stick_x), 32'(m_sx), "p1_stick_x");
    check_value(32'(p1_stick_y), 32'(m_sy), "p1_stick_y");
    check_value(32'(datatable_wren), 32'(m_wren), "datatable_wren");
    check_value(32'(datatable_addr), 32'(m_addr), "datatable_addr");
    if (m_wren) begin
      check_value(datatable_data, m_data, "datatable_data");
    end
    if (m_rom_valid) begin
      check_value(rom_file_size, m_rom, "rom_file_size");
    end
    check_value(32'(video_de), 32'(m_de), "video_de");
    check_value(32'(video_hs), 32'(m_hs), "video_hs");
    check_value(32'(video_vs), 32'(m_vs), "video_vs");
    check_value(32'(video_rgb), 32'(m_rgb), "video_rgb");
  endtask

  // one clock edge of the model with inputs already stable
  task automatic step_model();
    // video sees the 4:3 option from before this edge
    if (!(h_blank || v_blank)) begin
      m_rgb = rgb_in;
    end else if (m_de) begin
      m_rgb = status_word(pal, m_43);
    end else begin
      m_rgb = '0;
    end
    m_de      = !(h_blank || v_blank);
    m_hs      = hsync_in && !m_hs_prev;
    m_vs      = vsync_in && !m_vs_prev;
    m_hs_prev = hsync_in;
    m_vs_prev = vsync_in;

    if (stick_outside(cont1_joy[7:0], cont1_joy[15:8], m_dz)) begin
      m_sx = cont1_joy[7:0];
      m_sy = cont1_joy[15:8];
    end else begin
      m_sx = 8'd128;
      m_sy = 8'd128;
    end

    // phases 5 to 7 write the save size and the rest read the rom size
    if (m_phase == 3'd4) begin
      m_rom       = datatable_q;
      m_rom_valid = 1'b1;
    end
    if (m_phase >= 3'd5) begin
      m_wren = 1'b1;
      m_addr = 10'd3;
      m_data = save_bytes_for(sram_size);
    end else begin
      m_wren = 1'b0;
      m_addr = 10'd1;
    end
    m_phase = m_phase + 3'd1;

    if (hold_left != 0) begin
      hold_left--;
    end
    if (bridge_wr) begin
      case (bridge_addr)
        addr_soft_reset: hold_left = 256;
        addr_multitap:   m_multitap = bridge_wr_data[0];
        addr_input_mode: {m_mouse, m_lg_type, m_lg_en} = bridge_wr_data[2:0];
        addr_aim_speed:  m_aim = bridge_wr_data[7:0];
        addr_deadzone:   m_dz = bridge_wr_data[7:0];
        addr_video_mode: m_43 = bridge_wr_data[0];
        default: begin
        end
      endcase
    end
  endtask

  ////////////////////
  // comparing process

  always @(negedge clk_74a) begin
    if (!pll_core_locked) begin
      check_value(32'(core_reset), 32'd1, "core_reset during reset");
      reset_model();
    end else begin
      compare_outputs();
      step_model();
    end
  end

  ////////////////////
  // stimulus

  task automatic next_cycle();
    @(posedge clk_74a);
    #1;
  endtask

  task automatic bridge_write(input bridge_word_t addr, input bridge_word_t data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    next_cycle();
    bridge_wr = 1'b0;
  endtask

  task automatic write_options();
    bridge_word_t targets [6];
    logic [2:0]   pick;
    targets = '{addr_multitap, addr_input_mode, addr_aim_speed, addr_deadzone,
                addr_video_mode, 32'h0000_0300};
    repeat (60) begin
      pick = 3'($urandom_range(0, 5));
      bridge_write(targets[pick], $urandom);
    end
  endtask

  task automatic soft_reset_hold();
    int unsigned high_cycles;
    high_cycles = 0;
    bridge_write(addr_soft_reset, $urandom);
    @(negedge clk_74a);
    while (core_reset && high_cycles < 1000) begin
      high_cycles++;
      @(negedge clk_74a);
    end
    check_value(high_cycles, 32'd256, "core_reset cycles after soft reset");
    next_cycle();
  endtask

  task automatic stick_sweep();
    stick_axis_t x;
    stick_axis_t y;
    for (int i = 0; i < 300; i++) begin
      if (i % 25 == 0) begin
        bridge_write(addr_deadzone, $urandom);
      end
      // every other sample lands near center
      if (i % 2 == 0) begin
        x = 8'($urandom_range(100, 156));
        y = 8'($urandom_range(100, 156));
      end else begin
        x = 8'($urandom);
        y = 8'($urandom);
      end
      cont1_joy = {16'($urandom), y, x};
      next_cycle();
    end
  endtask

  task automatic poll_table();
    int unsigned wren_high;
    wren_high   = 0;
    sram_size   = 4'($urandom_range(1, 15));
    datatable_q = $urandom;
    @(negedge clk_74a);
    repeat (16) begin
      wren_high += 32'(datatable_wren);
      @(negedge clk_74a);
    end
    check_value(wren_high, 32'd6, "datatable_wren high cycles in 16");
    check_value(rom_file_size, datatable_q, "rom_file_size after hold");
    next_cycle();
    repeat (40) begin
      sram_size   = 4'($urandom);
      datatable_q = $urandom;
      next_cycle();
    end
    sram_size = '0;
    repeat (10) next_cycle();
  endtask

  task automatic video_lines();
    int unsigned active;
    for (int line = 0; line < 24; line++) begin
      bridge_write(addr_video_mode, $urandom);
      pal      = 1'($urandom);
      v_blank  = (line < 3);
      vsync_in = (line == 1);
      active   = $urandom_range(8, 32);
      h_blank  = 1'b0;
      repeat (active) begin
        rgb_in = 24'($urandom);
        next_cycle();
      end
      // pixels during blank must not reach the scaler
      h_blank = 1'b1;
      rgb_in  = 24'($urandom);
      repeat (3) next_cycle();
      hsync_in = 1'b1;
      repeat (4) next_cycle();
      hsync_in = 1'b0;
      repeat (3) next_cycle();
    end
  endtask

  initial begin
    void'($urandom(rand_seed));
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    cont1_joy       = 32'h0000_8080;
    sram_size       = '0;
    datatable_q     = '0;
    {h_blank, v_blank, hsync_in, vsync_in, pal} = 5'b11000;
    rgb_in          = '0;
    repeat (reset_cycles) @(posedge clk_74a);
    #1;
    pll_core_locked = 1'b1;
    repeat (4) next_cycle();
    write_options();
    soft_reset_hold();
    stick_sweep();
    poll_table();
    video_lines();
    repeat (4) next_cycle();
    $display("Simulation completed successfully");
    $finish;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk_74a);
      cycle_count++;
    end
    $display("ERROR: the test did not finish within %0d cycles", cycle_limit);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: verification/shell_props.sv
// concurrent checks on the data-table write pattern
// and on the scaler video outputs

`default_nettype none

module shell_props (
  input wire                  clk_74a,
  input wire                  pll_core_locked,
  input wire                  datatable_wren,
  input wire                  video_de,
  input wire                  video_hs,
  input wire                  video_vs,
  input wire shell_pkg::rgb_t video_rgb
);

  timeunit 1ns;
  timeprecision 100ps;

  import shell_pkg::*;

  rgb_t status_mask;

  assign status_mask = (rgb_t'(1) << slot_pal_bit) | (rgb_t'(1) << slot_43_bit);

  ////////////////////
  // data table

  // every write run is three cycles long
  wren_run: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $fell(datatable_wren) |-> $past(datatable_wren, 2) && $past(datatable_wren, 3)
                              && !$past(datatable_wren, 4))
    else $error("datatable_wren write run is not three cycles long");

  // at least five read cycles before the next run
  wren_gap: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(datatable_wren) |-> !$past(datatable_wren, 2) && !$past(datatable_wren, 3)
                              && !$past(datatable_wren, 4) && !$past(datatable_wren, 5))
    else $error("datatable_wren write runs closer than eight cycles");

  ////////////////////
  // video

  hs_pulse: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs)
    else $error("video_hs stayed high for two cycles");

  vs_pulse: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs)
    else $error("video_vs stayed high for two cycles");

  // outside the active region only the status flags may be set
  blank_rgb: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !video_de |-> (video_rgb & ~status_mask) == '0)
    else $error("pixel data present while video_de is low");

  status_slot: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (!video_de && video_rgb != '0) |-> $past(video_de))
    else $error("status word outside the first cycle after the active region");

endmodule

bind pocket_core_shell shell_props i_shell_props (
  .clk_74a         (clk_74a),
  .pll_core_locked (pll_core_locked),
  .datatable_wren  (datatable_wren),
  .video_de        (video_de),
  .video_hs        (video_hs),
  .video_vs        (video_vs),
  .video_rgb       (video_rgb)
);

`default_nettype wire

// File: rtl/pocket_core_shell.sv
// top level of the core control shell
// bridge settings on the input side, stick and data-table
// processing, video formatting on the output side

`default_nettype none

module pocket_core_shell (
  input  wire                              clk_74a,
  input  wire                              pll_core_locked,

  // host bridge
  input  wire shell_pkg::bridge_word_t     bridge_addr,
  input  wire                              bridge_wr,
  input  wire shell_pkg::bridge_word_t     bridge_wr_data,

  // core options
  output wire                              core_reset,
  output wire                              multitap_enabled,
  output wire                              lightgun_enabled,
  output wire                              lightgun_type,
  output wire                              mouse_enabled,
  output wire shell_pkg::stick_axis_t      dpad_aim_speed,

  // player 1 stick
  input  wire shell_pkg::bridge_word_t     cont1_joy,
  output wire shell_pkg::stick_axis_t      p1_stick_x,
  output wire shell_pkg::stick_axis_t      p1_stick_y,

  // data table
  input  wire shell_pkg::sram_size_t       sram_size,
  input  wire shell_pkg::bridge_word_t     datatable_q,
  output wire shell_pkg::datatable_addr_t  datatable_addr,
  output wire                              datatable_wren,
  output wire shell_pkg::bridge_word_t     datatable_data,
  output wire shell_pkg::bridge_word_t     rom_file_size,

  // video
  input  wire                              h_blank,
  input  wire                              v_blank,
  input  wire                              hsync_in,
  input  wire                              vsync_in,
  input  wire shell_pkg::rgb_t             rgb_in,
  input  wire                              pal,
  output wire                              video_de,
  output wire                              video_hs,
  output wire                              video_vs,
  output wire shell_pkg::rgb_t             video_rgb
);

  import shell_pkg::*;

  wire stick_axis_t joystick_deadzone;
  wire              use_4_3_video;

  ////////////////////
  // input side

  bridge_settings i_bridge_settings (
    .clk_74a           (clk_74a),
    .pll_core_locked   (pll_core_locked),
    .bridge_addr       (bridge_addr),
    .bridge_wr         (bridge_wr),
    .bridge_wr_data    (bridge_wr_data),
    .core_reset        (core_reset),
    .multitap_enabled  (multitap_enabled),
    .lightgun_enabled  (lightgun_enabled),
    .lightgun_type     (lightgun_type),
    .mouse_enabled     (mouse_enabled),
    .dpad_aim_speed    (dpad_aim_speed),
    .joystick_deadzone (joystick_deadzone),
    .use_4_3_video     (use_4_3_video)
  );

  ////////////////////
  // processing

  stick_deadzone i_stick_deadzone (
    .clk_74a           (clk_74a),
    .pll_core_locked   (pll_core_locked),
    .joy_raw           (cont1_joy),
    .joystick_deadzone (joystick_deadzone),
    .stick_x           (p1_stick_x),
    .stick_y           (p1_stick_y)
  );

  datatable_poller i_datatable_poller (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .sram_size       (sram_size),
    .datatable_q     (datatable_q),
    .datatable_addr  (datatable_addr),
    .datatable_wren  (datatable_wren),
    .datatable_data  (datatable_data),
    .rom_file_size   (rom_file_size)
  );

  ////////////////////
  // output side

  video_frame_formatter i_video_frame_formatter (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .h_blank         (h_blank),
    .v_blank         (v_blank),
    .hsync_in        (hsync_in),
    .vsync_in        (vsync_in),
    .rgb_in          (rgb_in),
    .pal             (pal),
    .use_4_3_video   (use_4_3_video),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

endmodule

`default_nettype wire

// File: rtl/video_frame_formatter.sv
// core video to scaler format
// data enable from blanks, one-cycle sync pulses,
// and the status word in the first cycle after each active line

`default_nettype none

module video_frame_formatter (
  input  wire                    clk_74a,
  input  wire                    pll_core_locked,
  input  wire                    h_blank,
  input  wire                    v_blank,
  input  wire                    hsync_in,
  input  wire                    vsync_in,
  input  wire shell_pkg::rgb_t   rgb_in,
  input  wire                    pal,
  input  wire                    use_4_3_video,
  output logic                   video_de,
  output logic                   video_hs,
  output logic                   video_vs,
  output shell_pkg::rgb_t        video_rgb
);

  import shell_pkg::*;

  logic de;
  logic hs_prev;
  logic vs_prev;
  rgb_t slot_word;

  assign de = !(h_blank || v_blank);

  // end-of-line status word with only the two mode flags set
  always_comb begin
    slot_word              = '0;
    slot_word[slot_pal_bit] = pal;
    slot_word[slot_43_bit]  = use_4_3_video;
  end

  ////////////////////
  // output registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_de <= de;
      if (de) begin
        video_rgb <= rgb_in;
      end else if (video_de) begin
        // last pixel went out one cycle ago
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end

      // rising edge of each core sync
      video_hs <= hsync_in && !hs_prev;
      video_vs <= vsync_in && !vs_prev;

      hs_prev <= hsync_in;
      vs_prev <= vsync_in;
    end
  end

endmodule

`default_nettype wire

// File: rtl/datatable_poller.sv
// free-running data-table sequencer
// phases 0-4 read the rom size slot, phases 5-7 write the save size

`default_nettype none

module datatable_poller (
  input  wire                          clk_74a,
  input  wire                          pll_core_locked,
  input  wire shell_pkg::sram_size_t   sram_size,
  input  wire shell_pkg::bridge_word_t datatable_q,
  output shell_pkg::datatable_addr_t   datatable_addr,
  output logic                         datatable_wren,
  output shell_pkg::bridge_word_t      datatable_data,
  output shell_pkg::bridge_word_t      rom_file_size
);

  import shell_pkg::*;

  poll_phase_t  phase;
  bridge_word_t save_bytes;

  // header code to bytes, zero means no save ram
  assign save_bytes = (sram_size != '0) ?
                      bridge_word_t'(1) << (sram_unit_shift + sram_size) : '0;

  ////////////////////
  // phase counter and table port

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      phase          <= '0;
      datatable_addr <= '0;
      datatable_wren <= 1'b0;
      datatable_data <= '0;
    end else begin
      phase <= phase + 3'd1;
      if (phase >= poll_write_first) begin
        datatable_wren <= 1'b1;
        datatable_addr <= sram_size_slot_addr;
        datatable_data <= save_bytes;
      end else begin
        // read side, data keeps the last write value
        datatable_wren <= 1'b0;
        datatable_addr <= rom_size_slot_addr;
      end
    end
  end

  // rom size sampled once the read address has settled
  always_ff @(posedge clk_74a) begin
    if (phase == poll_capture_phase) begin
      rom_file_size <= datatable_q;
    end
  end

endmodule

`default_nettype wire

// File: rtl/stick_deadzone.sv
// deadzone calibration of one analog stick
// both axes snap to center when the stick sits inside the deadzone

`default_nettype none

module stick_deadzone (
  input  wire                          clk_74a,
  input  wire                          pll_core_locked,
  input  wire shell_pkg::bridge_word_t joy_raw,
  input  wire shell_pkg::stick_axis_t  joystick_deadzone,
  output shell_pkg::stick_axis_t       stick_x,
  output shell_pkg::stick_axis_t       stick_y
);

  import shell_pkg::*;

  stick_axis_t raw_x;
  stick_axis_t raw_y;
  stick_axis_t dist_x;
  stick_axis_t dist_y;
  stick_sum_t  dist_total;
  logic        outside;

  // lstick x in the low byte, y above it
  assign raw_x = joy_raw[7:0];
  assign raw_y = joy_raw[15:8];

  // distance from center, 128 at full low deflection
  assign dist_x = raw_x[7] ? {1'b0, raw_x[6:0]} : stick_center - {1'b0, raw_x[6:0]};
  assign dist_y = raw_y[7] ? {1'b0, raw_y[6:0]} : stick_center - {1'b0, raw_y[6:0]};

  assign dist_total = {1'b0, dist_x} + {1'b0, dist_y};
  assign outside    = dist_total > {1'b0, joystick_deadzone};

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      stick_x <= stick_center;
      stick_y <= stick_center;
    end else begin
      stick_x <= outside ? raw_x : stick_center;
      stick_y <= outside ? raw_y : stick_center;
    end
  end

endmodule

`default_nettype wire

// File: rtl/bridge_settings.sv
// bridge write decode into core option registers
// plus the soft-reset hold counter that drives core_reset

`default_nettype none

module bridge_settings (
  input  wire                      clk_74a,
  input  wire                      pll_core_locked,
  input  wire shell_pkg::bridge_word_t bridge_addr,
  input  wire                      bridge_wr,
  input  wire shell_pkg::bridge_word_t bridge_wr_data,
  output logic                     core_reset,
  output logic                     multitap_enabled,
  output logic                     lightgun_enabled,
  output logic                     lightgun_type,
  output logic                     mouse_enabled,
  output shell_pkg::stick_axis_t   dpad_aim_speed,
  output shell_pkg::stick_axis_t   joystick_deadzone,
  output logic                     use_4_3_video
);

  import shell_pkg::*;

  bridge_word_t hold_count;

  ////////////////////
  // soft reset hold

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_count <= '0;
    end else if (bridge_wr && bridge_addr == addr_soft_reset) begin
      hold_count <= reset_hold_cycles;
    end else if (hold_count != '0) begin
      hold_count <= hold_count - 32'd1;
    end
  end

  // core held while the pll is unlocked or the hold runs
  assign core_reset = !pll_core_locked || (hold_count != '0);

  ////////////////////
  // option registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      multitap_enabled  <= 1'b0;
      lightgun_enabled  <= 1'b0;
      lightgun_type     <= 1'b0;
      mouse_enabled     <= 1'b0;
      dpad_aim_speed    <= '0;
      joystick_deadzone <= '0;
      use_4_3_video     <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        addr_multitap: begin
          multitap_enabled <= bridge_wr_data[0];
        end
        addr_input_mode: begin
          lightgun_enabled <= bridge_wr_data[0];
          lightgun_type    <= bridge_wr_data[1];
          mouse_enabled    <= bridge_wr_data[2];
        end
        addr_aim_speed: begin
          dpad_aim_speed <= bridge_wr_data[7:0];
        end
        addr_deadzone: begin
          joystick_deadzone <= bridge_wr_data[7:0];
        end
        addr_video_mode: begin
          use_4_3_video <= bridge_wr_data[0];
        end
        default: begin
          // other addresses leave the options alone
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/shell_pkg.sv
// shared definitions for the core control shell
// bridge register map, meaningful widths as typedefs,
// data-table slots, poller phases and video status bits

`default_nettype none

package shell_pkg;

  ////////////////////
  // widths

  typedef logic [31:0] bridge_word_t;
  typedef logic [7:0]  stick_axis_t;
  typedef logic [8:0]  stick_sum_t;
  typedef logic [23:0] rgb_t;
  typedef logic [9:0]  datatable_addr_t;
  typedef logic [3:0]  sram_size_t;
  typedef logic [2:0]  poll_phase_t;

  ////////////////////
  // bridge register map

  localparam bridge_word_t addr_soft_reset = 32'h0000_0050;
  localparam bridge_word_t addr_multitap   = 32'h0000_0100;
  localparam bridge_word_t addr_input_mode = 32'h0000_0104;
  localparam bridge_word_t addr_aim_speed  = 32'h0000_0108;
  localparam bridge_word_t addr_deadzone   = 32'h0000_010C;
  localparam bridge_word_t addr_video_mode = 32'h0000_0200;

  // kept short so simulation runs fast
  localparam bridge_word_t reset_hold_cycles = 32'd256;

  localparam stick_axis_t stick_center = 8'd128;

  ////////////////////
  // data table slots and poller phases

  localparam datatable_addr_t rom_size_slot_addr  = 10'd1;
  // slot index 1, times two plus one
  localparam datatable_addr_t sram_size_slot_addr = 10'd3;
  localparam int unsigned     sram_unit_shift     = 10;
  localparam poll_phase_t     poll_write_first    = 3'd5;
  localparam poll_phase_t     poll_capture_phase  = 3'd4;

  // end-of-line status word bits
  localparam int unsigned slot_pal_bit = 14;
  localparam int unsigned slot_43_bit  = 13;

endpackage

`default_nettype wire
